/* hdl/trig_readout_config.svh */
// fifo depths and readout busy times for the trigger readout front end
`ifndef TRIG_READOUT_CONFIG_SVH
`define TRIG_READOUT_CONFIG_SVH

// trigger words held by the trigger fifo
`define TRIG_FIFO_DEPTH 16

// acquisition summaries held by the acquisition fifo
`define ACQ_FIFO_DEPTH 16

// busy time of a full readout, in clk cycles
`define FULL_READOUT_CYCLES 8

// busy time of an empty-event readout, in clk cycles
// must be at least 1, like the full one
`define EMPTY_READOUT_CYCLES 2

`endif

/* hdl/trig_readout_pkg.sv */
// trigger word, acquisition word, event record and state index types
package trig_readout_pkg;

  localparam int NUM_STATES = 7; // width of the one-hot state vector

  // word from the TTC trigger fifo, 128 bits
  typedef struct packed {
    logic [25:0] spare;
    logic [ 3:0] alarms;    // XADC alarms
    logic        empty;     // empty-event request
    logic [ 4:0] trig_type;
    logic [23:0] event_num; // channel event number
    logic [23:0] trig_num;  // global trigger number
    logic [43:0] timestamp;
  } ttc_trigger_t;

  // acquisition summary from the channel logic, 32 bits
  typedef struct packed {
    logic [ 2:0] spare;
    logic [ 4:0] trig_type;
    logic [23:0] trig_num;
  } acq_event_t;

  // event header published by the sequencer, 102 bits
  typedef struct packed {
    logic        empty;
    logic [ 3:0] alarms;
    logic [ 4:0] trig_type;
    logic [23:0] event_num;
    logic [23:0] trig_num;
    logic [43:0] timestamp;
  } event_record_t;

  // bit positions in the one-hot state vector
  typedef enum logic [2:0] {
    IDLE             = 3'd0,
    READ_TRIG_FIFO   = 3'd1,
    SEND_EMPTY_EVENT = 3'd2,
    READ_ACQ_FIFO    = 3'd3,
    READOUT          = 3'd4,
    ERROR_TRIG_NUM   = 3'd5,
    ERROR_TRIG_TYPE  = 3'd6
  } proc_state_e;

endpackage

/* hdl/event_fifo.sv */
// first-word-fall-through synchronous fifo, parameterised width and depth
`timescale 1ns/10ps

module event_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             reset,

  // write side, no back-pressure
  input  logic             wr_valid,
  input  logic [WIDTH-1:0] wr_data,
  output logic             full,

  // read side
  output logic             rd_valid,
  output logic [WIDTH-1:0] rd_data,
  input  logic             rd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count; // words held

  logic wr_en;
  logic rd_en;

  assign full     = (count == CNT_W'(DEPTH));
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr]; // head word falls through

  assign wr_en = wr_valid & ~full; // push while full is dropped
  assign rd_en = rd_valid & rd_ready;

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

endmodule

/* hdl/trigger_processor.sv */
// one-hot fsm pairing trigger and acquisition words and starting readouts
`timescale 1ns/10ps

module trigger_processor import trig_readout_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,

  // trigger fifo read side
  input  logic                  trig_fifo_valid,
  input  ttc_trigger_t          trig_fifo_data,
  output logic                  trig_fifo_ready,

  // acquisition fifo read side
  input  logic                  acq_fifo_valid,
  input  acq_event_t            acq_fifo_data,
  output logic                  acq_fifo_ready,

  // readout sequencer
  input  logic                  readout_ready,    // sequencer idle
  input  logic                  readout_done,     // readout finished
  output logic                  send_empty_event, // empty-event request
  output logic                  initiate_readout, // start a readout
  output event_record_t         trig_record,      // latched trigger fields

  // status
  output logic [NUM_STATES-1:0] state,
  output logic                  error_trig_num,
  output logic                  error_trig_type
);

  acq_event_t acq_latched; // last acquisition summary taken

  logic [NUM_STATES-1:0] nextstate;
  event_record_t         next_trig_record;
  acq_event_t            next_acq_latched;

  always_comb begin
    nextstate        = '0;
    next_trig_record = trig_record; // hold unless a word is accepted
    next_acq_latched = acq_latched;

    trig_fifo_ready  = 1'b0;
    acq_fifo_ready   = 1'b0;
    send_empty_event = 1'b0;
    initiate_readout = 1'b0;

    case (1'b1)
      state[IDLE]: begin
        if (trig_fifo_valid) begin
          next_trig_record.alarms    = trig_fifo_data.alarms;
          next_trig_record.empty     = trig_fifo_data.empty;
          next_trig_record.trig_type = trig_fifo_data.trig_type;
          next_trig_record.event_num = trig_fifo_data.event_num;
          next_trig_record.trig_num  = trig_fifo_data.trig_num;
          next_trig_record.timestamp = trig_fifo_data.timestamp;

          trig_fifo_ready = 1'b1; // pop the trigger word
          nextstate[READ_TRIG_FIFO] = 1'b1;
        end
        else begin
          nextstate[IDLE] = 1'b1;
        end
      end

      state[READ_TRIG_FIFO]: begin
        // empty events skip the acquisition fifo entirely
        if (trig_record.empty & readout_ready) begin
          send_empty_event = 1'b1;
          initiate_readout = 1'b1;
          nextstate[SEND_EMPTY_EVENT] = 1'b1;
        end
        else if (acq_fifo_valid & ~trig_record.empty) begin
          next_acq_latched = acq_fifo_data;
          acq_fifo_ready   = 1'b1; // pop the acquisition word
          nextstate[READ_ACQ_FIFO] = 1'b1;
        end
        else begin
          nextstate[READ_TRIG_FIFO] = 1'b1; // wait for sequencer or acq word
        end
      end

      state[SEND_EMPTY_EVENT]: begin
        if (readout_done) begin
          nextstate[IDLE] = 1'b1;
        end
        else begin
          nextstate[SEND_EMPTY_EVENT] = 1'b1;
        end
      end

      state[READ_ACQ_FIFO]: begin
        // number is checked before type
        if (trig_record.trig_num != acq_latched.trig_num) begin
          nextstate[ERROR_TRIG_NUM] = 1'b1;
        end
        else if (trig_record.trig_type != acq_latched.trig_type) begin
          nextstate[ERROR_TRIG_TYPE] = 1'b1;
        end
        else if (readout_ready) begin
          initiate_readout = 1'b1;
          nextstate[READOUT] = 1'b1;
        end
        else begin
          nextstate[READ_ACQ_FIFO] = 1'b1; // sequencer still busy
        end
      end

      state[READOUT]: begin
        if (readout_done) begin
          nextstate[IDLE] = 1'b1;
        end
        else begin
          nextstate[READOUT] = 1'b1;
        end
      end

      // mismatches are sticky until reset
      state[ERROR_TRIG_NUM]: begin
        nextstate[ERROR_TRIG_NUM] = 1'b1;
      end

      state[ERROR_TRIG_TYPE]: begin
        nextstate[ERROR_TRIG_TYPE] = 1'b1;
      end

      default: begin
        nextstate[IDLE] = 1'b1; // lost one-hot, fall back to idle
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= NUM_STATES'(1) << IDLE;
      trig_record <= '0;
      acq_latched <= '0;
    end
    else begin
      state       <= nextstate;
      trig_record <= next_trig_record;
      acq_latched <= next_acq_latched;
    end
  end

  assign error_trig_num  = state[ERROR_TRIG_NUM];
  assign error_trig_type = state[ERROR_TRIG_TYPE];

endmodule

/* hdl/readout_sequencer.sv */
// command manager model publishing event headers and timing readouts
`timescale 1ns/10ps
`include "trig_readout_config.svh"

module readout_sequencer import trig_readout_pkg::*; (
  input  logic          clk,
  input  logic          reset,

  // requests from the trigger processor
  input  logic          initiate_readout,
  input  logic          send_empty_event,
  input  event_record_t trig_record,

  // status back to the processor
  output logic          readout_ready, // idle level
  output logic          readout_done,  // one-cycle pulse

  // published header
  output logic          event_valid,
  output event_record_t event_record
);

  localparam int MAX_CYCLES = (`FULL_READOUT_CYCLES > `EMPTY_READOUT_CYCLES) ?
                              `FULL_READOUT_CYCLES : `EMPTY_READOUT_CYCLES;
  localparam int CNT_W = $clog2(MAX_CYCLES + 1);

  localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(`FULL_READOUT_CYCLES);
  localparam logic [CNT_W-1:0] EMPTY_CNT = CNT_W'(`EMPTY_READOUT_CYCLES);

  logic             busy;
  logic [CNT_W-1:0] busy_cnt; // cycles left in the readout
  logic             start;
  event_record_t    next_record;

  assign readout_ready = ~busy;
  assign start         = initiate_readout & ~busy; // ignore requests while busy

  // empty flag follows the request, not the latched trigger
  always_comb begin
    next_record       = trig_record;
    next_record.empty = send_empty_event;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy         <= 1'b0;
      busy_cnt     <= '0;
      readout_done <= 1'b0;
      event_valid  <= 1'b0;
      event_record <= '0;
    end
    else begin
      readout_done <= 1'b0;
      event_valid  <= start; // header one cycle after the request

      if (start) begin
        busy         <= 1'b1;
        busy_cnt     <= send_empty_event ? EMPTY_CNT : FULL_CNT;
        event_record <= next_record;
      end
      else if (busy) begin
        busy_cnt <= busy_cnt - 1'b1;
        if (busy_cnt == CNT_W'(1)) begin
          busy         <= 1'b0; // ready rises with done
          readout_done <= 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/trig_readout_top.sv */
// top level with trigger and acquisition fifos, processor and sequencer
`timescale 1ns/10ps
`include "trig_readout_config.svh"

module trig_readout_top import trig_readout_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,

  // input streams
  input  logic                  trig_in_valid,
  input  ttc_trigger_t          trig_in_data,
  input  logic                  acq_in_valid,
  input  acq_event_t            acq_in_data,
  output logic                  trig_fifo_full,
  output logic                  acq_fifo_full,

  // event headers
  output logic                  event_valid,
  output event_record_t         event_record,

  // status
  output logic [NUM_STATES-1:0] proc_state,
  output logic                  error_trig_num,
  output logic                  error_trig_type
);

  logic          trig_fifo_valid;
  logic          trig_fifo_ready;
  ttc_trigger_t  trig_fifo_data;

  logic          acq_fifo_valid;
  logic          acq_fifo_ready;
  acq_event_t    acq_fifo_data;

  logic          readout_ready;
  logic          readout_done;
  logic          send_empty_event;
  logic          initiate_readout;
  event_record_t trig_record;

  event_fifo #(
    .WIDTH ($bits(ttc_trigger_t)),
    .DEPTH (`TRIG_FIFO_DEPTH)
  ) trig_fifo_i (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (trig_in_valid),
    .wr_data  (trig_in_data),
    .full     (trig_fifo_full),
    .rd_valid (trig_fifo_valid),
    .rd_data  (trig_fifo_data),
    .rd_ready (trig_fifo_ready)
  );

  event_fifo #(
    .WIDTH ($bits(acq_event_t)),
    .DEPTH (`ACQ_FIFO_DEPTH)
  ) acq_fifo_i (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (acq_in_valid),
    .wr_data  (acq_in_data),
    .full     (acq_fifo_full),
    .rd_valid (acq_fifo_valid),
    .rd_data  (acq_fifo_data),
    .rd_ready (acq_fifo_ready)
  );

  trigger_processor trigger_processor_i (
    .clk              (clk),
    .reset            (reset),
    .trig_fifo_valid  (trig_fifo_valid),
    .trig_fifo_data   (trig_fifo_data),
    .trig_fifo_ready  (trig_fifo_ready),
    .acq_fifo_valid   (acq_fifo_valid),
    .acq_fifo_data    (acq_fifo_data),
    .acq_fifo_ready   (acq_fifo_ready),
    .readout_ready    (readout_ready),
    .readout_done     (readout_done),
    .send_empty_event (send_empty_event),
    .initiate_readout (initiate_readout),
    .trig_record      (trig_record),
    .state            (proc_state),
    .error_trig_num   (error_trig_num),
    .error_trig_type  (error_trig_type)
  );

  readout_sequencer readout_sequencer_i (
    .clk              (clk),
    .reset            (reset),
    .initiate_readout (initiate_readout),
    .send_empty_event (send_empty_event),
    .trig_record      (trig_record),
    .readout_ready    (readout_ready),
    .readout_done     (readout_done),
    .event_valid      (event_valid),
    .event_record     (event_record)
  );

endmodule

/* tb/trig_readout_sva.sv */
// concurrent checks on the trigger processor fsm and the readout sequencer, with bind
`timescale 1ns/10ps

module trig_readout_sva import trig_readout_pkg::*; (
  input logic                  clk,
  input logic                  reset,
  input logic [NUM_STATES-1:0] state,
  input logic                  initiate_readout,
  input logic                  readout_ready,
  input logic                  readout_done,
  input logic                  event_valid
);

  state_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(state))
    else $error("processor state vector is not one-hot: %b", state);

  // no request while the sequencer is busy
  start_when_ready: assert property (@(posedge clk) disable iff (reset)
    initiate_readout |-> readout_ready)
    else $error("initiate_readout raised while readout_ready is low");

  header_follows: assert property (@(posedge clk) disable iff (reset)
    initiate_readout |=> event_valid)
    else $error("event_valid missing one cycle after initiate_readout");

  header_has_request: assert property (@(posedge clk) disable iff (reset)
    event_valid |-> $past(initiate_readout))
    else $error("event_valid without initiate_readout one cycle before");

  // done only ends a readout that was running
  done_not_idle: assert property (@(posedge clk) disable iff (reset)
    readout_done |-> $past(!readout_ready) && (state[READOUT] || state[SEND_EMPTY_EVENT]))
    else $error("readout_done while no readout was in progress");

endmodule

// processor and sequencer signals are reached through the top level
bind trig_readout_top trig_readout_sva sva_i (
  .clk              (clk),
  .reset            (reset),
  .state            (proc_state),
  .initiate_readout (initiate_readout),
  .readout_ready    (readout_ready),
  .readout_done     (readout_done),
  .event_valid      (event_valid)
);

/* tb/trig_readout_tb.sv */
// testbench for the trigger readout front end with lfsr stimulus and a record checker
`timescale 1ns/10ps
`include "trig_readout_config.svh"

module trig_readout_tb import trig_readout_pkg::*; ();

  logic                  clk;
  logic                  reset;
  logic                  trig_in_valid;
  ttc_trigger_t          trig_in_data;
  logic                  acq_in_valid;
  acq_event_t            acq_in_data;
  logic                  trig_fifo_full;
  logic                  acq_fifo_full;
  logic                  event_valid;
  event_record_t         event_record;
  logic [NUM_STATES-1:0] proc_state;
  logic                  error_trig_num;
  logic                  error_trig_type;

  logic [31:0]   lfsr_state = 32'hd09517aa;
  event_record_t exp_q[$];  // expected headers in push order
  event_record_t exp_rec;
  ttc_trigger_t  held_trig[$];
  int            records_seen;
  int            expected_total;

  trig_readout_top dut_i (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic ttc_trigger_t random_trigger();
    ttc_trigger_t t;
    t.spare     = 26'(take_bits(26));
    t.alarms    = 4'(take_bits(4));
    t.empty     = 1'(take_bits(1));
    t.trig_type = 5'(take_bits(5));
    t.event_num = 24'(take_bits(24));
    t.trig_num  = 24'(take_bits(24));
    t.timestamp = 44'(take_bits(44));
    return t;
  endfunction

  function automatic acq_event_t matching_acq(input ttc_trigger_t t);
    acq_event_t a;
    a.spare     = 3'(take_bits(3));
    a.trig_type = t.trig_type;
    a.trig_num  = t.trig_num;
    return a;
  endfunction

  // header expected for a trigger word copies every field but the spare bits
  function automatic event_record_t expected_record(input ttc_trigger_t t);
    event_record_t r;
    r.empty     = t.empty;
    r.alarms    = t.alarms;
    r.trig_type = t.trig_type;
    r.event_num = t.event_num;
    r.trig_num  = t.trig_num;
    r.timestamp = t.timestamp;
    return r;
  endfunction

  task automatic end_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0d ns: %s", $time, what);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic push_words(input logic do_trig, input ttc_trigger_t t,
                            input logic do_acq, input acq_event_t a);
    trig_in_valid = do_trig;
    trig_in_data  = t;
    acq_in_valid  = do_acq;
    acq_in_data   = a;
    @(posedge clk);
    #2;
    trig_in_valid = 1'b0;
    acq_in_valid  = 1'b0;
  endtask

  task automatic send_event(input ttc_trigger_t t, input logic with_acq);
    exp_q.push_back(expected_record(t));
    expected_total++;
    push_words(1'b1, t, with_acq, matching_acq(t));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_queue_below(input int limit, input int max_cycles, input string what);
    int cycles = 0;
    while (exp_q.size() > limit) begin
      if (cycles >= max_cycles) report_problem({"timeout waiting for ", what});
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  task automatic wait_error(input logic type_err, input int max_cycles);
    int cycles = 0;
    while ((type_err ? error_trig_type : error_trig_num) !== 1'b1) begin
      if (cycles >= max_cycles) report_problem("timeout waiting for a mismatch error flag");
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  task automatic apply_reset();
    reset         = 1'b1;
    trig_in_valid = 1'b0;
    acq_in_valid  = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    check_value("proc_state", proc_state, NUM_STATES'(1) << IDLE);
    check_value("error_trig_num", error_trig_num, 0);
    check_value("error_trig_type", error_trig_type, 0);
    check_value("trig_fifo_full", trig_fifo_full, 0);
    check_value("acq_fifo_full", acq_fifo_full, 0);
  endtask

  // compare each published header against the oldest expected one
  always @(negedge clk) begin
    if (!reset && event_valid === 1'b1) begin
      assert (exp_q.size() != 0) else report_problem("event record with no trigger outstanding");
      exp_rec = exp_q.pop_front();
      check_value("event_record.empty", event_record.empty, exp_rec.empty);
      check_value("event_record.alarms", event_record.alarms, exp_rec.alarms);
      check_value("event_record.trig_type", event_record.trig_type, exp_rec.trig_type);
      check_value("event_record.event_num", event_record.event_num, exp_rec.event_num);
      check_value("event_record.trig_num", event_record.trig_num, exp_rec.trig_num);
      check_value("event_record.timestamp", event_record.timestamp, exp_rec.timestamp);
      records_seen++;
    end
  end

  initial begin
    ttc_trigger_t t;
    ttc_trigger_t t2;
    acq_event_t   a;
    int           seen;
    reset = 1'b1;
    trig_in_valid = 1'b0;
    trig_in_data = '0;
    acq_in_valid = 1'b0;
    acq_in_data = '0;
    records_seen = 0;
    expected_total = 0;
    apply_reset();

    // full event gives exactly one record
    t = random_trigger();
    t.empty = 1'b0;
    send_event(t, 1'b1);
    wait_queue_below(0, 100, "the full event record");
    idle_cycles(`FULL_READOUT_CYCLES + 4);
    check_value("records_seen", records_seen, expected_total);

    // empty event leaves the acq word for the next trigger
    t = random_trigger();
    t.empty = 1'b1;
    t2 = random_trigger();
    t2.empty = 1'b0;
    exp_q.push_back(expected_record(t));
    exp_q.push_back(expected_record(t2));
    expected_total += 2;
    push_words(1'b1, t, 1'b1, matching_acq(t2));
    push_words(1'b1, t2, 1'b0, '0);
    wait_queue_below(1, 50, "the empty event record");
    check_value("acq_fifo_valid", dut_i.acq_fifo_valid, 1);
    check_value("acq_fifo_data.trig_num", dut_i.acq_fifo_data.trig_num, t2.trig_num);
    wait_queue_below(0, 100, "the record paired after the empty event");

    // burst while readouts are busy
    for (int i = 0; i < 6; i++) begin
      t = random_trigger();
      t.empty = (i % 3 == 1);
      send_event(t, !t.empty);
    end
    wait_queue_below(0, 400, "the burst records");
    idle_cycles(`FULL_READOUT_CYCLES + 4);

    // overfill the trigger fifo while one word sits in the processor
    for (int i = 0; i < `TRIG_FIFO_DEPTH + 2; i++) begin
      t = random_trigger();
      t.empty = 1'b0;
      if (i <= `TRIG_FIFO_DEPTH) begin
        held_trig.push_back(t);
        exp_q.push_back(expected_record(t));
        expected_total++;
      end
      push_words(1'b1, t, 1'b0, '0);
    end
    check_value("trig_fifo_full", trig_fifo_full, 1);
    for (int k = 0; k < held_trig.size(); k++) begin
      push_words(1'b0, '0, 1'b1, matching_acq(held_trig[k]));
      wait_queue_below(held_trig.size() - k - 1, 100, "a record after its acquisition word");
    end
    idle_cycles(`FULL_READOUT_CYCLES + 4);

    // trigger number mismatch is sticky
    t = random_trigger();
    t.empty = 1'b0;
    a = matching_acq(t);
    a.trig_num = t.trig_num + 24'd1;
    push_words(1'b1, t, 1'b1, a);
    wait_error(1'b0, 50);
    seen = records_seen;
    t = random_trigger();
    t.empty = 1'b0;
    push_words(1'b1, t, 1'b1, matching_acq(t));
    idle_cycles(40);
    check_value("error_trig_num", error_trig_num, 1);
    check_value("records_seen", records_seen, seen);
    // acquisition words pile up behind the stuck fsm
    for (int i = 0; i < `ACQ_FIFO_DEPTH; i++) begin
      push_words(1'b0, '0, 1'b1, '0);
    end
    check_value("acq_fifo_full", acq_fifo_full, 1);
    apply_reset();
    t = random_trigger();
    send_event(t, !t.empty);
    wait_queue_below(0, 100, "a record after reset");
    idle_cycles(`FULL_READOUT_CYCLES + 4);

    // type mismatch with equal numbers
    t = random_trigger();
    t.empty = 1'b0;
    a = matching_acq(t);
    a.trig_type = t.trig_type ^ 5'd1;
    push_words(1'b1, t, 1'b1, a);
    wait_error(1'b1, 50);
    check_value("error_trig_num", error_trig_num, 0);
    apply_reset();

    // random run with up to six records outstanding
    for (int i = 0; i < 200; i++) begin
      wait_queue_below(5, 200, "the random run backlog");
      t = random_trigger();
      send_event(t, !t.empty);
      idle_cycles(int'(take_bits(2)));
    end
    wait_queue_below(0, 2000, "the random run records");
    idle_cycles(`FULL_READOUT_CYCLES + 4);
    check_value("records_seen", records_seen, expected_total);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* list.f */
+incdir+hdl
hdl/trig_readout_pkg.sv
hdl/event_fifo.sv
hdl/trigger_processor.sv
hdl/readout_sequencer.sv
hdl/trig_readout_top.sv
tb/trig_readout_sva.sv
tb/trig_readout_tb.sv
